// ==== rtl/sort_pkg.sv ====
/*
 * sort engine package
 * group size, slot and channel types, FSM state encodings
 */
package sort_pkg;

  // records per group, the network is fixed at four
  localparam int group_items = 4;

  // position of a record inside a group
  typedef logic [1:0] slot_t;

  // client channel number
  typedef logic [0:0] chan_t;

  // arbiter FSM
  // idle picks a channel, locked holds it for a whole group
  typedef enum logic {
    arb_idle,
    arb_locked
  } arb_state_e;

  // emitter FSM
  // empty accepts a sorted group, busy streams it out
  typedef enum logic {
    emit_empty,
    emit_busy
  } emit_state_e;

endpackage

// ==== rtl/compare_and_swap.sv ====
/*
 * compare and swap cell
 * orders two records by a key bit field, smaller key on the low side
 */
`timescale 1ns/1ps

module compare_and_swap #(
  parameter int data_w_p             = 16,
  parameter int key_hi_p             = 15,
  parameter int key_lo_p             = 8,
  parameter bit cond_swap_on_equal_p = 1'b0
) (
  input  logic [data_w_p-1:0] a_i,
  input  logic [data_w_p-1:0] b_i,
  input  logic                swap_on_equal_i,
  output logic [data_w_p-1:0] lo_o,
  output logic [data_w_p-1:0] hi_o,
  output logic                swapped_o
);

  logic [key_hi_p-key_lo_p:0] key_a;
  logic [key_hi_p-key_lo_p:0] key_b;
  logic                       keys_equal;
  logic                       do_swap;

  // key is an inclusive bit range, everything else is payload
  assign key_a = a_i[key_hi_p:key_lo_p];
  assign key_b = b_i[key_hi_p:key_lo_p];

  assign keys_equal = (key_a == key_b);

  // strictly greater always swaps
  // equal keys swap only when the instance is built for it and asked to
  assign do_swap = (key_a > key_b)
                || (keys_equal && cond_swap_on_equal_p && swap_on_equal_i);

  assign lo_o      = do_swap ? b_i : a_i;
  assign hi_o      = do_swap ? a_i : b_i;
  assign swapped_o = do_swap;

endmodule

// ==== rtl/sort4_stable.sv ====
/*
 * stable four record sorting network
 * five compare and swap cells, ascending key, equal keys keep arrival order
 */
`timescale 1ns/1ps

module sort4_stable #(
  parameter int data_w_p = 16,
  parameter int key_hi_p = 15,
  parameter int key_lo_p = 8
) (
  input  logic                clk_i,
  input  logic [data_w_p-1:0] in0_i,
  input  logic [data_w_p-1:0] in1_i,
  input  logic [data_w_p-1:0] in2_i,
  input  logic [data_w_p-1:0] in3_i,
  output logic [data_w_p-1:0] out0_o,
  output logic [data_w_p-1:0] out1_o,
  output logic [data_w_p-1:0] out2_o,
  output logic [data_w_p-1:0] out3_o
);

  // records after stage one and stage two
  logic [data_w_p-1:0]        s1 [sort_pkg::group_items];
  logic [data_w_p-1:0]        s2 [sort_pkg::group_items];
  logic                       swapped_2_0;
  logic                       swapped_3_1;
  logic [key_hi_p-key_lo_p:0] k0;
  logic [key_hi_p-key_lo_p:0] k1;
  logic [key_hi_p-key_lo_p:0] k2;
  logic [key_hi_p-key_lo_p:0] k3;

  // stage one orders the adjacent pairs <1,0> and <3,2>
  compare_and_swap #(.data_w_p(data_w_p), .key_hi_p(key_hi_p), .key_lo_p(key_lo_p)) cas_1_0 (
    .a_i(in0_i), .b_i(in1_i), .swap_on_equal_i(1'b0),
    .lo_o(s1[0]), .hi_o(s1[1]), .swapped_o()
  );

  compare_and_swap #(.data_w_p(data_w_p), .key_hi_p(key_hi_p), .key_lo_p(key_lo_p)) cas_3_2 (
    .a_i(in2_i), .b_i(in3_i), .swap_on_equal_i(1'b0),
    .lo_o(s1[2]), .hi_o(s1[3]), .swapped_o()
  );

  // stage two merges the pairs through <2,0> and <3,1>
  // either swap can leave a later record ahead of an earlier one with the same key
  compare_and_swap #(.data_w_p(data_w_p), .key_hi_p(key_hi_p), .key_lo_p(key_lo_p)) cas_2_0 (
    .a_i(s1[0]), .b_i(s1[2]), .swap_on_equal_i(1'b0),
    .lo_o(s2[0]), .hi_o(s2[2]), .swapped_o(swapped_2_0)
  );

  compare_and_swap #(.data_w_p(data_w_p), .key_hi_p(key_hi_p), .key_lo_p(key_lo_p)) cas_3_1 (
    .a_i(s1[1]), .b_i(s1[3]), .swap_on_equal_i(1'b0),
    .lo_o(s2[1]), .hi_o(s2[3]), .swapped_o(swapped_3_1)
  );

  // stage three orders the middle pair <2,1>
  // after any stage two swap the upper middle record arrived first,
  // so equal keys swap back into arrival order
  compare_and_swap #(
    .data_w_p(data_w_p), .key_hi_p(key_hi_p), .key_lo_p(key_lo_p),
    .cond_swap_on_equal_p(1'b1)
  ) cas_2_1 (
    .a_i(s2[1]), .b_i(s2[2]), .swap_on_equal_i(swapped_2_0 || swapped_3_1),
    .lo_o(out1_o), .hi_o(out2_o), .swapped_o()
  );

  // outer records are final after stage two
  assign out0_o = s2[0];
  assign out3_o = s2[3];

  assign k0 = out0_o[key_hi_p:key_lo_p];
  assign k1 = out1_o[key_hi_p:key_lo_p];
  assign k2 = out2_o[key_hi_p:key_lo_p];
  assign k3 = out3_o[key_hi_p:key_lo_p];

  // keys leave the network in non decreasing order
  // inputs are unknown until the gather has filled its first group
  a_keys_ordered : assert property (
    @(posedge clk_i) disable iff ($isunknown({in0_i, in1_i, in2_i, in3_i}))
    (k0 <= k1) && (k1 <= k2) && (k2 <= k3)
  ) else $error("sort4_stable: output keys out of order");

endmodule

// ==== rtl/group_arbiter.sv ====
/*
 * group arbiter
 * round robin over two channels, grant held for a whole group of records
 */
`timescale 1ns/1ps

module group_arbiter #(
  parameter int data_w_p = 16
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                in0_valid_i,
  input  logic [data_w_p-1:0] in0_data_i,
  output logic                in0_ready_o,
  input  logic                in1_valid_i,
  input  logic [data_w_p-1:0] in1_data_i,
  output logic                in1_ready_o,
  output logic                rec_valid_o,
  output logic [data_w_p-1:0] rec_data_o,
  output sort_pkg::chan_t     rec_chan_o,
  input  logic                rec_ready_i
);

  sort_pkg::arb_state_e state_q;
  sort_pkg::chan_t      grant_q;
  sort_pkg::chan_t      pick;
  sort_pkg::slot_t      cnt_q;
  logic                 locked;
  logic                 xfer;
  logic                 last_xfer;

  // both waiting means the one not served last time wins
  // grant_q resets to channel 1 so channel 0 goes first
  always_comb begin
    if (in0_valid_i && in1_valid_i) begin
      pick = ~grant_q;
    end else if (in1_valid_i) begin
      pick = sort_pkg::chan_t'(1);
    end else begin
      pick = sort_pkg::chan_t'(0);
    end
  end

  assign locked = (state_q == sort_pkg::arb_locked);

  // only the granted channel sees the downstream ready
  assign in0_ready_o = locked && (grant_q == sort_pkg::chan_t'(0)) && rec_ready_i;
  assign in1_ready_o = locked && (grant_q == sort_pkg::chan_t'(1)) && rec_ready_i;

  assign rec_valid_o = locked && (grant_q[0] ? in1_valid_i : in0_valid_i);
  assign rec_data_o  = grant_q[0] ? in1_data_i : in0_data_i;
  assign rec_chan_o  = grant_q;

  assign xfer      = rec_valid_o && rec_ready_i;
  assign last_xfer = xfer && (cnt_q == sort_pkg::slot_t'(sort_pkg::group_items - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= sort_pkg::arb_idle;
      grant_q <= sort_pkg::chan_t'(1);
      cnt_q   <= '0;
    end else begin
      case (state_q)
        sort_pkg::arb_idle: begin
          if (in0_valid_i || in1_valid_i) begin
            state_q <= sort_pkg::arb_locked;
            grant_q <= pick;
            cnt_q   <= '0;
          end
        end
        sort_pkg::arb_locked: begin
          // count records of the group, counter wraps to zero on the fourth
          if (xfer) begin
            cnt_q <= cnt_q + sort_pkg::slot_t'(1);
          end
          if (last_xfer) begin
            state_q <= sort_pkg::arb_idle;
          end
        end
        default: state_q <= sort_pkg::arb_idle;
      endcase
    end
  end

  // a record is only ever taken from one client at a time
  a_one_ready : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !(in0_ready_o && in1_ready_o)
  ) else $error("group_arbiter: both channel readies high");

endmodule

// ==== rtl/group_gather.sv ====
/*
 * group gather
 * collects four records of one channel and holds them until taken
 */
`timescale 1ns/1ps

module group_gather #(
  parameter int data_w_p = 16
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                rec_valid_i,
  input  logic [data_w_p-1:0] rec_data_i,
  input  sort_pkg::chan_t     rec_chan_i,
  output logic                rec_ready_o,
  output logic                grp_valid_o,
  output logic [data_w_p-1:0] grp_data0_o,
  output logic [data_w_p-1:0] grp_data1_o,
  output logic [data_w_p-1:0] grp_data2_o,
  output logic [data_w_p-1:0] grp_data3_o,
  output sort_pkg::chan_t     grp_chan_o,
  input  logic                grp_ready_i
);

  logic [data_w_p-1:0] slot_q [sort_pkg::group_items];
  sort_pkg::slot_t     cnt_q;
  sort_pkg::chan_t     chan_q;
  logic                full_q;
  logic                accept;

  // no new records while a complete group waits
  assign rec_ready_o = !full_q;
  assign accept      = rec_valid_i && rec_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      full_q <= 1'b0;
    end else begin
      if (accept) begin
        cnt_q <= cnt_q + sort_pkg::slot_t'(1);
        // fourth record completes the group
        if (cnt_q == sort_pkg::slot_t'(sort_pkg::group_items - 1)) begin
          full_q <= 1'b1;
        end
      end
      if (full_q && grp_ready_i) begin
        full_q <= 1'b0;
      end
    end
  end

  // payload, written in arrival order
  always_ff @(posedge clk_i) begin
    if (accept) begin
      slot_q[cnt_q] <= rec_data_i;
      chan_q        <= rec_chan_i;
    end
  end

  assign grp_valid_o = full_q;
  assign grp_data0_o = slot_q[0];
  assign grp_data1_o = slot_q[1];
  assign grp_data2_o = slot_q[2];
  assign grp_data3_o = slot_q[3];
  assign grp_chan_o  = chan_q;

  // the arbiter keeps one channel for the whole group,
  // so every record after the first repeats the latched channel
  a_chan_locked : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    accept && (cnt_q != '0) |-> (rec_chan_i == chan_q)
  ) else $error("group_gather: channel changed inside a group");

endmodule

// ==== rtl/group_emitter.sv ====
/*
 * group emitter
 * loads a sorted group and sends it one record per cycle with back-pressure
 */
`timescale 1ns/1ps

module group_emitter #(
  parameter int data_w_p = 16
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                grp_valid_i,
  input  logic [data_w_p-1:0] grp_data0_i,
  input  logic [data_w_p-1:0] grp_data1_i,
  input  logic [data_w_p-1:0] grp_data2_i,
  input  logic [data_w_p-1:0] grp_data3_i,
  input  sort_pkg::chan_t     grp_chan_i,
  output logic                grp_ready_o,
  output logic                out_valid_o,
  output logic [data_w_p-1:0] out_data_o,
  output sort_pkg::chan_t     out_chan_o,
  output logic                out_last_o,
  input  logic                out_ready_i
);

  sort_pkg::emit_state_e state_q;
  sort_pkg::slot_t       idx_q;
  sort_pkg::chan_t       chan_q;
  logic [data_w_p-1:0]   buf_q [sort_pkg::group_items];
  logic                  load;
  logic                  xfer;
  logic                  at_last;

  assign grp_ready_o = (state_q == sort_pkg::emit_empty);
  assign load        = grp_valid_i && grp_ready_o;

  assign out_valid_o = (state_q == sort_pkg::emit_busy);
  assign xfer        = out_valid_o && out_ready_i;
  assign at_last     = (idx_q == sort_pkg::slot_t'(sort_pkg::group_items - 1));

  assign out_data_o = buf_q[idx_q];
  assign out_chan_o = chan_q;
  assign out_last_o = out_valid_o && at_last;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= sort_pkg::emit_empty;
      idx_q   <= '0;
    end else begin
      case (state_q)
        sort_pkg::emit_empty: begin
          if (grp_valid_i) begin
            state_q <= sort_pkg::emit_busy;
            idx_q   <= '0;
          end
        end
        sort_pkg::emit_busy: begin
          // step one slot per accepted record, index wraps after the last
          if (xfer) begin
            idx_q <= idx_q + sort_pkg::slot_t'(1);
            if (at_last) begin
              state_q <= sort_pkg::emit_empty;
            end
          end
        end
        default: state_q <= sort_pkg::emit_empty;
      endcase
    end
  end

  // sorted group and its channel, captured when the group is taken
  always_ff @(posedge clk_i) begin
    if (load) begin
      buf_q[0] <= grp_data0_i;
      buf_q[1] <= grp_data1_i;
      buf_q[2] <= grp_data2_i;
      buf_q[3] <= grp_data3_i;
      chan_q   <= grp_chan_i;
    end
  end

  // a stalled record stays offered and unchanged until it is taken
  a_hold_stall : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o)
  ) else $error("group_emitter: output changed while stalled");

endmodule

// ==== rtl/sort_engine_top.sv ====
/*
 * sort engine top level
 * two client channels, group arbiter, gather, stable sort network, emitter
 */
`timescale 1ns/1ps

module sort_engine_top #(
  parameter int data_w_p = 16,
  parameter int key_hi_p = 15,
  parameter int key_lo_p = 8
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                in0_valid_i,
  input  logic [data_w_p-1:0] in0_data_i,
  output logic                in0_ready_o,
  input  logic                in1_valid_i,
  input  logic [data_w_p-1:0] in1_data_i,
  output logic                in1_ready_o,
  output logic                out_valid_o,
  output logic [data_w_p-1:0] out_data_o,
  output sort_pkg::chan_t     out_chan_o,
  output logic                out_last_o,
  input  logic                out_ready_i
);

  // arbiter to gather
  logic                rec_valid;
  logic [data_w_p-1:0] rec_data;
  sort_pkg::chan_t     rec_chan;
  logic                rec_ready;

  // gather to sorter and emitter
  logic                grp_valid;
  logic [data_w_p-1:0] grp_data0;
  logic [data_w_p-1:0] grp_data1;
  logic [data_w_p-1:0] grp_data2;
  logic [data_w_p-1:0] grp_data3;
  sort_pkg::chan_t     grp_chan;
  logic                grp_ready;

  // sorter to emitter, same cycle
  logic [data_w_p-1:0] sorted0;
  logic [data_w_p-1:0] sorted1;
  logic [data_w_p-1:0] sorted2;
  logic [data_w_p-1:0] sorted3;

  group_arbiter #(.data_w_p(data_w_p)) u_arbiter (
    .clk_i, .rst_n_i,
    .in0_valid_i, .in0_data_i, .in0_ready_o,
    .in1_valid_i, .in1_data_i, .in1_ready_o,
    .rec_valid_o(rec_valid), .rec_data_o(rec_data),
    .rec_chan_o(rec_chan), .rec_ready_i(rec_ready)
  );

  group_gather #(.data_w_p(data_w_p)) u_gather (
    .clk_i, .rst_n_i,
    .rec_valid_i(rec_valid), .rec_data_i(rec_data),
    .rec_chan_i(rec_chan), .rec_ready_o(rec_ready),
    .grp_valid_o(grp_valid),
    .grp_data0_o(grp_data0), .grp_data1_o(grp_data1),
    .grp_data2_o(grp_data2), .grp_data3_o(grp_data3),
    .grp_chan_o(grp_chan), .grp_ready_i(grp_ready)
  );

  sort4_stable #(.data_w_p(data_w_p), .key_hi_p(key_hi_p), .key_lo_p(key_lo_p)) u_sort (
    .clk_i,
    .in0_i(grp_data0), .in1_i(grp_data1), .in2_i(grp_data2), .in3_i(grp_data3),
    .out0_o(sorted0), .out1_o(sorted1), .out2_o(sorted2), .out3_o(sorted3)
  );

  group_emitter #(.data_w_p(data_w_p)) u_emitter (
    .clk_i, .rst_n_i,
    .grp_valid_i(grp_valid),
    .grp_data0_i(sorted0), .grp_data1_i(sorted1),
    .grp_data2_i(sorted2), .grp_data3_i(sorted3),
    .grp_chan_i(grp_chan), .grp_ready_o(grp_ready),
    .out_valid_o, .out_data_o, .out_chan_o, .out_last_o, .out_ready_i
  );

endmodule

// ==== tb/sort_model.svh ====
/*
 * reference model for the sort engine testbench
 * stable insertion sort on the key field, expected output kept in grant order
 */

// expected output records, one entry per output transfer
rec_t exp_data [$];
logic exp_chan [$];
logic exp_last [$];

// records promised to the output so far
int   tx_count = 0;

// channel of the latest grant
// starts at 1 so that channel 0 wins the first tie after reset
int   last_grant = 1;

// key bit field of a record
function automatic logic [key_hi-key_lo:0] key_of(input rec_t r);
  return r[key_hi:key_lo];
endfunction

// sorts one group and queues its records as they must leave the engine
task automatic expect_group(input int ch, input rec_t r0, input rec_t r1,
                            input rec_t r2, input rec_t r3);
  rec_t s [0:3];
  rec_t t;
  int   i;
  int   j;
  s[0] = r0;
  s[1] = r1;
  s[2] = r2;
  s[3] = r3;
  // ascending insertion sort
  // a record only moves past strictly larger keys, equal keys stay in arrival order
  for (i = 1; i < sort_pkg::group_items; i++) begin
    t = s[i];
    j = i - 1;
    while (j >= 0) begin
      if (key_of(s[j]) <= key_of(t)) begin
        break;
      end
      s[j + 1] = s[j];
      j = j - 1;
    end
    s[j + 1] = t;
  end
  // channel rides with every record, last flag on the fourth only
  for (i = 0; i < sort_pkg::group_items; i++) begin
    exp_data.push_back(s[i]);
    exp_chan.push_back(ch != 0);
    exp_last.push_back(i == sort_pkg::group_items - 1);
  end
  tx_count   = tx_count + sort_pkg::group_items;
  last_grant = ch;
endtask

// ==== tb/tb_sort_engine.sv ====
/*
 * testbench for the sort engine
 * directed tests on ordering, stability, channel alternation and back-pressure
 */
`timescale 1ns/1ps

module tb_sort_engine;

  localparam int data_w       = 16;
  localparam int key_hi       = 15;
  localparam int key_lo       = 8;
  localparam int clk_period   = 10;
  localparam int reset_cycles = 4;
  // groups sent by all tests together
  localparam int total_groups   = 59;
  localparam int timeout_cycles = total_groups * 20 + reset_cycles;

  typedef logic [data_w-1:0] rec_t;

  logic            clk;
  logic            rst_n;
  logic            in0_valid;
  rec_t            in0_data;
  logic            in0_ready;
  logic            in1_valid;
  rec_t            in1_data;
  logic            in1_ready;
  logic            out_valid;
  rec_t            out_data;
  sort_pkg::chan_t out_chan;
  logic            out_last;
  logic            out_ready;

  integer seed = 32'hbef17aef;
  int     seq_no = 0;
  int     rx_count = 0;
  logic   stall_done;
  rec_t   e_data;
  logic   e_chan;
  logic   e_last;

  `include "sort_model.svh"

  sort_engine_top #(.data_w_p(data_w), .key_hi_p(key_hi), .key_lo_p(key_lo)) UUT (
    .clk_i(clk), .rst_n_i(rst_n),
    .in0_valid_i(in0_valid), .in0_data_i(in0_data), .in0_ready_o(in0_ready),
    .in1_valid_i(in1_valid), .in1_data_i(in1_data), .in1_ready_o(in1_ready),
    .out_valid_o(out_valid), .out_data_o(out_data), .out_chan_o(out_chan),
    .out_last_o(out_last), .out_ready_i(out_ready)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic report_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at the first mismatch");
  endtask

  // key in the key field, running sequence number in the payload
  function automatic rec_t make_rec(input int key);
    rec_t r;
    r = '0;
    r[key_hi:key_lo] = key[key_hi-key_lo:0];
    r[key_lo-1:0]    = seq_no[key_lo-1:0];
    seq_no = seq_no + 1;
    return r;
  endfunction

  // called 1 ns after an edge, returns 1 ns after the edge that took the record
  task automatic drive_record(input int ch, input rec_t r);
    logic got;
    got = 1'b0;
    if (ch == 0) begin
      in0_valid = 1'b1;
      in0_data  = r;
    end else begin
      in1_valid = 1'b1;
      in1_data  = r;
    end
    // ready is settled by the falling edge and holds until the rising edge
    while (!got) begin
      @(negedge clk);
      got = (ch == 0) ? in0_ready : in1_ready;
      @(posedge clk);
    end
    #1;
  endtask

  task automatic send_group(input int ch, input rec_t r0, input rec_t r1,
                            input rec_t r2, input rec_t r3);
    drive_record(ch, r0);
    drive_record(ch, r1);
    drive_record(ch, r2);
    drive_record(ch, r3);
    if (ch == 0) begin
      in0_valid = 1'b0;
    end else begin
      in1_valid = 1'b0;
    end
  endtask

  // one group at a time, so grant order is send order
  task automatic send_keys(input int ch, input int k0, input int k1,
                           input int k2, input int k3);
    rec_t r0;
    rec_t r1;
    rec_t r2;
    rec_t r3;
    r0 = make_rec(k0);
    r1 = make_rec(k1);
    r2 = make_rec(k2);
    r3 = make_rec(k3);
    expect_group(ch, r0, r1, r2, r3);
    send_group(ch, r0, r1, r2, r3);
  endtask

  task automatic wait_drain();
    while (exp_data.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic check_reset_state();
    @(negedge clk);
    assert (!in0_ready && !in1_ready && !out_valid && !out_last)
      else report_error("ready or valid high after reset");
    @(posedge clk);
    #1;
  endtask

  task automatic test_single_group();
    send_keys(0, 9, 3, 12, 6);
    wait_drain();
  endtask

  task automatic test_equal_keys();
    send_keys(0, 5, 5, 5, 5);
    send_keys(1, 7, 3, 7, 1);
    send_keys(0, 4, 4, 2, 4);
    // larger halves 5 and 2 trade places, then the two key 2 records must be put back
    send_keys(1, 2, 5, 1, 2);
    wait_drain();
  endtask

  task automatic test_alternating_channels();
    rec_t recs [0:1][0:2][0:3];
    int   c;
    int   g;
    int   i;
    int   g0;
    int   g1;
    int   ch;
    int   first;
    for (c = 0; c < 2; c++) begin
      for (g = 0; g < 3; g++) begin
        for (i = 0; i < 4; i++) begin
          recs[c][g][i] = make_rec((c * 53 + g * 29 + i * 71) & 'h1f);
        end
      end
    end
    // both wait from the start, so grants alternate beginning with the other channel
    first = 1 - last_grant;
    for (i = 0; i < 6; i++) begin
      ch = first ^ (i % 2);
      g  = i / 2;
      expect_group(ch, recs[ch][g][0], recs[ch][g][1], recs[ch][g][2], recs[ch][g][3]);
    end
    fork
      for (g0 = 0; g0 < 3; g0++) begin
        send_group(0, recs[0][g0][0], recs[0][g0][1], recs[0][g0][2], recs[0][g0][3]);
      end
      for (g1 = 0; g1 < 3; g1++) begin
        send_group(1, recs[1][g1][0], recs[1][g1][1], recs[1][g1][2], recs[1][g1][3]);
      end
    join
    wait_drain();
  endtask

  task automatic test_back_pressure();
    int g;
    stall_done = 1'b0;
    fork
      begin
        for (g = 0; g < 8; g++) begin
          send_keys(g % 2, (g * 37) & 'hff, (g * 91 + 13) & 'hff,
                    (g * 37) & 'hff, (g * 17 + 200) & 'hff);
        end
        while (exp_data.size() != 0) begin
          @(posedge clk);
        end
        stall_done = 1'b1;
      end
      // random output stalls until every record has left
      while (!stall_done) begin
        @(posedge clk);
        #1;
        out_ready = ($random(seed) & 1) != 0;
      end
    join
    out_ready = 1'b1;
    wait_drain();
  endtask

  task automatic test_random_groups();
    int g;
    int ch;
    int mask;
    int k0;
    int k1;
    int k2;
    int k3;
    for (g = 0; g < 40; g++) begin
      ch = $random(seed) & 1;
      // narrow keys on every other group to get many ties
      mask = (g % 2 == 0) ? 'hff : 'h3;
      k0 = $random(seed) & mask;
      k1 = $random(seed) & mask;
      k2 = $random(seed) & mask;
      k3 = $random(seed) & mask;
      send_keys(ch, k0, k1, k2, k3);
    end
    wait_drain();
  endtask

  // every output transfer against the head of the expected queue
  initial begin
    forever begin
      @(negedge clk);
      if (out_valid && out_ready) begin
        assert (exp_data.size() != 0)
          else report_error("output record arrived with none expected");
        e_data = exp_data.pop_front();
        e_chan = exp_chan.pop_front();
        e_last = exp_last.pop_front();
        assert (out_data === e_data)
          else report_error($sformatf("data %h, expected %h", out_data, e_data));
        assert (out_chan === e_chan)
          else report_error($sformatf("channel %0d, expected %0d", out_chan, e_chan));
        assert (out_last === e_last)
          else report_error($sformatf("last flag %0b, expected %0b", out_last, e_last));
        rx_count = rx_count + 1;
      end
    end
  end

  initial begin
    #(timeout_cycles * clk_period);
    $display("timeout: the run did not finish within %0d clock cycles", timeout_cycles);
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    in0_valid  = 1'b0;
    in0_data   = '0;
    in1_valid  = 1'b0;
    in1_data   = '0;
    out_ready  = 1'b1;
    stall_done = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_reset_state();
    test_single_group();
    test_equal_keys();
    test_alternating_channels();
    test_back_pressure();
    test_random_groups();
    if (rx_count == tx_count && exp_data.size() == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      report_error($sformatf("received %0d records, expected %0d", rx_count, tx_count));
    end
  end

endmodule

// ==== tb.f ====
+incdir+tb
rtl/sort_pkg.sv
rtl/compare_and_swap.sv
rtl/sort4_stable.sv
rtl/group_arbiter.sv
rtl/group_gather.sv
rtl/group_emitter.sv
rtl/sort_engine_top.sv
tb/tb_sort_engine.sv
